// File: huf_pkg.sv
//--------------------------------------------------------------------
// Sizes, vector types and controller states of the Huffman tree builder.
//--------------------------------------------------------------------
package huf_pkg;

  localparam int unsigned num_sym   = 16;  // Symbol slots per block.
  localparam int unsigned sym_w     = 4;
  localparam int unsigned freq_w    = 12;
  localparam int unsigned depth_w   = 4;
  localparam int unsigned row_w     = 5;   // Holds num_sym as well.
  localparam int unsigned rebuild_w = 4;

  localparam int unsigned cfg_max_len_default       = 15;
  localparam int unsigned cfg_rebuild_limit_default = 3;

  typedef logic [sym_w-1:0]     sym_t;
  typedef logic [freq_w-1:0]    freq_t;
  typedef logic [depth_w-1:0]   depth_t;
  typedef logic [row_w-1:0]     row_t;
  typedef logic [rebuild_w-1:0] rebuild_cnt_t;

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_build,
    st_drain,
    st_check,
    st_stall
  } htb_state_e;

endpackage

// File: htb_cfg_regs.sv
//--------------------------------------------------------------------
// Configuration registers for the maximum code length and rebuild limit.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module htb_cfg_regs import huf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         cfg_wr,
  input  logic         cfg_addr,
  input  rebuild_cnt_t cfg_wdata,
  output depth_t       max_len,
  output rebuild_cnt_t rebuild_limit
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      max_len       <= depth_t'(cfg_max_len_default);
      rebuild_limit <= rebuild_cnt_t'(cfg_rebuild_limit_default);
    end
    else if (cfg_wr)
    begin
      if (cfg_addr)
      begin
        rebuild_limit <= cfg_wdata;  // Address 1 is the rebuild limit.
      end
      else
      begin
        max_len <= depth_t'(cfg_wdata);  // Address 0 is the maximum length.
      end
    end
  end

  // A zero maximum length would make every build fail.
  a_max_len_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cfg_wr && !cfg_addr) |=> (max_len != '0)
  );

endmodule

// File: htb_input_store.sv
//--------------------------------------------------------------------
// Input block capture, zero-entry count and rebuild-scaled frequencies.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module htb_input_store import huf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  freq_t        sym_freq [num_sym],
  input  sym_t         sym_id [num_sym],
  input  rebuild_cnt_t rebuild_cnt,
  output freq_t        scaled_freq [num_sym],
  output sym_t         stored_sym [num_sym],
  output row_t         zero_cnt,
  output logic         all_zero
);

  freq_t stored_freq [num_sym];
  row_t  zero_nxt;

  // The block is sorted ascending, so the zero entries lead the table.
  always_comb
  begin
    zero_nxt = '0;
    for (int i = 0; i < num_sym; i++)
    begin
      if (sym_freq[i] == '0)
        zero_nxt = zero_nxt + 1'b1;
    end
  end

  // A new block is only offered while the builder is idle.
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      stored_freq <= sym_freq;
      stored_sym  <= sym_id;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      zero_cnt <= '0;
    else if (start)
      zero_cnt <= zero_nxt;
  end

  assign all_zero = (zero_cnt == row_t'(num_sym));

  always_comb
  begin
    freq_t shifted;
    for (int i = 0; i < num_sym; i++)
    begin
      shifted = stored_freq[i] >> rebuild_cnt;
      if (stored_freq[i] != '0 && shifted == '0)
        scaled_freq[i] = freq_t'(1);  // A used symbol keeps a weight of at least 1.
      else
        scaled_freq[i] = shifted;
    end
  end

endmodule

// File: htb_merge_engine.sv
//--------------------------------------------------------------------
// Sorted work table with one two-smallest merge per build cycle.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module htb_merge_engine import huf_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load,
  input  logic  build,
  input  freq_t scaled_freq [num_sym],
  input  sym_t  stored_sym [num_sym],
  input  row_t  zero_cnt,
  output logic  merge,
  output logic  pick_is_node [2],
  output row_t  pick_ref [2],
  output logic  pick_nonzero [2],
  output row_t  new_row,
  output logic  last_merge
);

  logic  tab_node [num_sym];
  row_t  tab_ref [num_sym];
  freq_t tab_w [num_sym];
  row_t  row_ptr;

  // The node of the last merge is inserted into the table on the next merge.
  logic  pend_valid;
  row_t  pend_ref;
  freq_t pend_w;

  logic [num_sym:0] le;
  logic             ins_node [num_sym];
  row_t             ins_ref [num_sym];
  freq_t            ins_w [num_sym];
  freq_t            pick_w [2];
  freq_t            sum_w;
  logic [sym_w-1:0] idx0;
  logic [sym_w-1:0] idx1;
  logic [sym_w-1:0] idx2;
  logic             two_ahead;

  assign merge      = build && (row_ptr < row_t'(num_sym - 1));
  assign last_merge = merge && (row_ptr == row_t'(num_sym - 2));
  assign new_row    = row_ptr;  // Each merge names its node after the current row.

  //--------------------------------------------------------------------
  // Pick the two smallest live entries.
  //--------------------------------------------------------------------
  always_comb
  begin
    idx0      = row_ptr[sym_w-1:0];
    idx1      = idx0 + 1'b1;
    idx2      = idx0 + 2'd2;
    two_ahead = (row_ptr < row_t'(num_sym - 2));

    pick_is_node[0] = tab_node[idx0];
    pick_ref[0]     = tab_ref[idx0];
    pick_w[0]       = tab_w[idx0];
    pick_is_node[1] = tab_node[idx1];
    pick_ref[1]     = tab_ref[idx1];
    pick_w[1]       = tab_w[idx1];

    // With a pending node, row_ptr itself is already consumed.
    if (pend_valid)
    begin
      if (pend_w < tab_w[idx1])
      begin
        pick_is_node[0] = 1'b1;
        pick_ref[0]     = pend_ref;
        pick_w[0]       = pend_w;
      end
      else
      begin
        pick_is_node[0] = tab_node[idx1];
        pick_ref[0]     = tab_ref[idx1];
        pick_w[0]       = tab_w[idx1];
        if (!two_ahead || pend_w < tab_w[idx2])
        begin
          pick_is_node[1] = 1'b1;
          pick_ref[1]     = pend_ref;
          pick_w[1]       = pend_w;
        end
        else
        begin
          pick_is_node[1] = tab_node[idx2];
          pick_ref[1]     = tab_ref[idx2];
          pick_w[1]       = tab_w[idx2];
        end
      end
    end

    for (int j = 0; j < 2; j++)
      pick_nonzero[j] = (pick_w[j] != '0);
    sum_w = pick_w[0] + pick_w[1];  // Block totals are expected to fit in freq_w.
  end

  //--------------------------------------------------------------------
  // Insert the pending node behind all live rows of equal or lower weight.
  //--------------------------------------------------------------------
  always_comb
  begin
    int nxt;
    le[num_sym] = 1'b0;
    for (int i = 0; i < num_sym; i++)
      le[i] = pend_valid && (row_t'(i) > row_ptr) && (tab_w[i] <= pend_w);
    for (int i = 0; i < num_sym; i++)
    begin
      nxt = (i < num_sym - 1) ? i + 1 : i;
      if (le[i+1])
      begin
        ins_node[i] = tab_node[nxt];  // Lighter rows move down by one.
        ins_ref[i]  = tab_ref[nxt];
        ins_w[i]    = tab_w[nxt];
      end
      else if (le[i] || row_t'(i) == row_ptr)
      begin
        ins_node[i] = 1'b1;
        ins_ref[i]  = pend_ref;
        ins_w[i]    = pend_w;
      end
      else
      begin
        ins_node[i] = tab_node[i];
        ins_ref[i]  = tab_ref[i];
        ins_w[i]    = tab_w[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_ptr    <= '0;
      pend_valid <= 1'b0;
    end
    else if (load)
    begin
      row_ptr    <= zero_cnt;  // Zero-weight rows never take part.
      pend_valid <= 1'b0;
    end
    else if (merge)
    begin
      row_ptr    <= row_ptr + 1'b1;
      pend_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      for (int i = 0; i < num_sym; i++)
      begin
        tab_node[i] <= 1'b0;
        tab_ref[i]  <= row_t'(stored_sym[i]);
        tab_w[i]    <= scaled_freq[i];
      end
    end
    else if (merge)
    begin
      if (pend_valid)
      begin
        tab_node <= ins_node;
        tab_ref  <= ins_ref;
        tab_w    <= ins_w;
      end
      pend_ref <= row_ptr;
      pend_w   <= sum_w;
    end
  end

  a_row_ptr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    row_ptr <= row_t'(num_sym)
  );

endmodule

// File: htb_depth_tracker.sv
//--------------------------------------------------------------------
// Per-symbol node table, depth update and code length limit check.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module htb_depth_tracker import huf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   load,
  input  logic   merge,
  input  logic   pick_is_node [2],
  input  row_t   pick_ref [2],
  input  logic   pick_nonzero [2],
  input  row_t   new_row,
  input  depth_t max_len,
  output depth_t sym_depth [num_sym],
  output logic   over_limit
);

  logic   merge_q;
  logic   is_node_q [2];
  row_t   ref_q [2];
  logic   nonzero_q [2];
  row_t   new_row_q;

  logic   in_tree [num_sym];   // Symbol already sits under a node.
  row_t   node_of [num_sym];
  logic   in_tree_nxt [num_sym];
  row_t   node_of_nxt [num_sym];
  depth_t depth_nxt [num_sym];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      merge_q <= 1'b0;
    else
      merge_q <= merge;
  end

  always_ff @(posedge clk)
  begin
    is_node_q <= pick_is_node;
    ref_q     <= pick_ref;
    nonzero_q <= pick_nonzero;
    new_row_q <= new_row;
  end

  always_comb
  begin
    in_tree_nxt = in_tree;
    node_of_nxt = node_of;
    depth_nxt   = sym_depth;
    for (int i = 0; i < num_sym; i++)
    begin
      if (load)
      begin
        in_tree_nxt[i] = 1'b0;
        depth_nxt[i]   = '0;
      end
      else if (merge_q)
      begin
        for (int j = 0; j < 2; j++)
        begin
          if (!is_node_q[j] && nonzero_q[j] && ref_q[j] == row_t'(i))
          begin
            in_tree_nxt[i] = 1'b1;  // A leaf enters the tree one level deep.
            node_of_nxt[i] = new_row_q;
            depth_nxt[i]   = depth_t'(1);
          end
          else if (is_node_q[j] && nonzero_q[j] && in_tree[i] && node_of[i] == ref_q[j])
          begin
            node_of_nxt[i] = new_row_q;
            depth_nxt[i]   = sym_depth[i] + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < num_sym; i++)
      begin
        in_tree[i]   <= 1'b0;
        sym_depth[i] <= '0;
      end
    end
    else
    begin
      in_tree   <= in_tree_nxt;
      sym_depth <= depth_nxt;
    end
  end

  always_ff @(posedge clk)
  begin
    node_of <= node_of_nxt;
  end

  always_comb
  begin
    over_limit = 1'b0;
    for (int i = 0; i < num_sym; i++)
    begin
      if (sym_depth[i] > max_len)
        over_limit = 1'b1;
    end
  end

endmodule

// File: htb_ctrl.sv
//--------------------------------------------------------------------
// Build FSM, rebuild counter, status and completion pulses.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module htb_ctrl import huf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  logic         all_zero,
  input  logic         last_merge,
  input  logic         over_limit,
  input  rebuild_cnt_t rebuild_limit,
  input  logic         out_stall,
  output logic         load,
  output logic         build,
  output rebuild_cnt_t rebuild_cnt,
  output logic         busy,
  output logic         done,
  output logic         zero_symbols,
  output logic         build_error,
  output logic         rebuild_pulse,
  output logic         rebuild_failed
);

  htb_state_e state;
  htb_state_e state_nxt;
  logic       at_limit;
  logic       do_rebuild;
  logic       do_fail;

  assign at_limit   = (rebuild_cnt >= rebuild_limit);
  assign do_rebuild = (state == st_check) && over_limit && !at_limit;
  assign do_fail    = (state == st_check) && over_limit && at_limit;

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:  if (start) state_nxt = st_load;
      st_load:
      begin
        if (!all_zero)
          state_nxt = st_build;
        else
          state_nxt = out_stall ? st_stall : st_idle;  // Nothing to build.
      end
      st_build: if (last_merge) state_nxt = st_drain;
      st_drain: state_nxt = st_check;  // Depth tracker applies the last merge.
      st_check:
      begin
        if (do_rebuild)
          state_nxt = st_load;
        else
          state_nxt = out_stall ? st_stall : st_idle;
      end
      st_stall: if (!out_stall) state_nxt = st_idle;
      default:  state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      rebuild_cnt   <= '0;
      done          <= 1'b0;
      zero_symbols  <= 1'b0;
      build_error   <= 1'b0;
      rebuild_pulse <= 1'b0;
    end
    else
    begin
      state         <= state_nxt;
      done          <= (state != st_idle) && (state_nxt == st_idle);
      rebuild_pulse <= do_rebuild;
      if (state == st_idle && start)
      begin
        rebuild_cnt  <= '0;
        zero_symbols <= 1'b0;
        build_error  <= 1'b0;
      end
      if (state == st_load && all_zero)
        zero_symbols <= 1'b1;
      if (do_rebuild)
        rebuild_cnt <= rebuild_cnt + 1'b1;
      if (do_fail)
        build_error <= 1'b1;
    end
  end

  assign load           = (state == st_load);
  assign build          = (state == st_build);
  assign busy           = (state != st_idle) || done;
  assign rebuild_failed = done && build_error;

  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !done
  );

endmodule

// File: huf_tree_builder.sv
//--------------------------------------------------------------------
// Huffman code-length builder top level for a 16-symbol block.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module huf_tree_builder import huf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  freq_t        sym_freq [num_sym],
  input  sym_t         sym_id [num_sym],
  input  logic         out_stall,
  input  logic         cfg_wr,
  input  logic         cfg_addr,
  input  rebuild_cnt_t cfg_wdata,
  output logic         busy,
  output logic         done,
  output depth_t       sym_depth [num_sym],
  output logic         zero_symbols,
  output logic         build_error,
  output logic         rebuild_pulse,
  output logic         rebuild_failed
);

  depth_t       max_len;
  rebuild_cnt_t rebuild_limit;
  rebuild_cnt_t rebuild_cnt;
  freq_t        scaled_freq [num_sym];
  sym_t         stored_sym [num_sym];
  row_t         zero_cnt;
  logic         all_zero;
  logic         load;
  logic         build;
  logic         merge;
  logic         pick_is_node [2];
  row_t         pick_ref [2];
  logic         pick_nonzero [2];
  row_t         new_row;
  logic         last_merge;
  logic         over_limit;

  htb_cfg_regs cfg_regs_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .max_len       (max_len),
    .rebuild_limit (rebuild_limit)
  );

  htb_input_store input_store_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .sym_freq    (sym_freq),
    .sym_id      (sym_id),
    .rebuild_cnt (rebuild_cnt),
    .scaled_freq (scaled_freq),
    .stored_sym  (stored_sym),
    .zero_cnt    (zero_cnt),
    .all_zero    (all_zero)
  );

  htb_merge_engine merge_engine_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .build        (build),
    .scaled_freq  (scaled_freq),
    .stored_sym   (stored_sym),
    .zero_cnt     (zero_cnt),
    .merge        (merge),
    .pick_is_node (pick_is_node),
    .pick_ref     (pick_ref),
    .pick_nonzero (pick_nonzero),
    .new_row      (new_row),
    .last_merge   (last_merge)
  );

  htb_depth_tracker depth_tracker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .merge        (merge),
    .pick_is_node (pick_is_node),
    .pick_ref     (pick_ref),
    .pick_nonzero (pick_nonzero),
    .new_row      (new_row),
    .max_len      (max_len),
    .sym_depth    (sym_depth),
    .over_limit   (over_limit)
  );

  htb_ctrl ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .all_zero       (all_zero),
    .last_merge     (last_merge),
    .over_limit     (over_limit),
    .rebuild_limit  (rebuild_limit),
    .out_stall      (out_stall),
    .load           (load),
    .build          (build),
    .rebuild_cnt    (rebuild_cnt),
    .busy           (busy),
    .done           (done),
    .zero_symbols   (zero_symbols),
    .build_error    (build_error),
    .rebuild_pulse  (rebuild_pulse),
    .rebuild_failed (rebuild_failed)
  );

endmodule

// File: tb_huf_tree_builder.sv
//--------------------------------------------------------------------
// Testbench for the Huffman tree builder with directed tests, tree
// checks, LFSR stimulus and a cycle watchdog.
//--------------------------------------------------------------------
`timescale 1ns/1ps

module tb_huf_tree_builder import huf_pkg::*;
();

  localparam int num_tests       = 6;
  localparam int cycles_per_test = 400;
  localparam int max_cycles      = num_tests * cycles_per_test;
  localparam int stall_cycles    = 20;

  logic         clk;
  logic         rst_n;
  logic         start;
  freq_t        sym_freq [num_sym];
  sym_t         sym_id [num_sym];
  logic         out_stall;
  logic         cfg_wr;
  logic         cfg_addr;
  rebuild_cnt_t cfg_wdata;
  logic         busy;
  logic         done;
  depth_t       sym_depth [num_sym];
  logic         zero_symbols;
  logic         build_error;
  logic         rebuild_pulse;
  logic         rebuild_failed;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt;
  int          freq_of_sym [num_sym];  // Block contents by symbol number.
  logic [15:0] lfsr_state;

  huf_tree_builder huf_tree_builder_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .sym_freq       (sym_freq),
    .sym_id         (sym_id),
    .out_stall      (out_stall),
    .cfg_wr         (cfg_wr),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .busy           (busy),
    .done           (done),
    .sym_depth      (sym_depth),
    .zero_symbols   (zero_symbols),
    .build_error    (build_error),
    .rebuild_pulse  (rebuild_pulse),
    .rebuild_failed (rebuild_failed)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: no result after %0d clock cycles", max_cycles);
    $display("Testbench failed");
    $finish;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic int random_bits(input int n);
    int val;
    val = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
    return val;
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  task automatic cfg_write(input logic addr, input int data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = rebuild_cnt_t'(data);
    @(posedge clk);
    #1;
    cfg_wr    = 1'b0;
  endtask

  // Sorts the block ascending by frequency and keeps ties in symbol order.
  task automatic drive_sorted();
    int f_list [num_sym];
    int s_list [num_sym];
    int tf;
    int ts;
    int j;
    for (int i = 0; i < num_sym; i++)
    begin
      f_list[i] = freq_of_sym[i];
      s_list[i] = i;
    end
    for (int i = 1; i < num_sym; i++)
    begin
      tf = f_list[i];
      ts = s_list[i];
      j  = i - 1;
      while (j >= 0 && f_list[j] > tf)
      begin
        f_list[j+1] = f_list[j];
        s_list[j+1] = s_list[j];
        j--;
      end
      f_list[j+1] = tf;
      s_list[j+1] = ts;
    end
    for (int i = 0; i < num_sym; i++)
    begin
      sym_freq[i] = freq_t'(f_list[i]);
      sym_id[i]   = sym_t'(s_list[i]);
    end
  endtask

  task automatic start_build();
    drive_sorted();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done(output int pulses, output logic failed_at_done);
    pulses = 0;
    while (done !== 1'b1)
    begin
      if (rebuild_pulse === 1'b1)
        pulses++;
      if (rebuild_failed === 1'b1)
      begin
        $display("[ERROR] %0d ns: rebuild_failed pulsed outside the done cycle", $time);
        errors++;
      end
      compare_val("busy", busy, 1);
      @(posedge clk);
      #1;
    end
    compare_val("busy", busy, 1);
    failed_at_done = rebuild_failed;
  endtask

  // A complete prefix code has a Kraft sum of 2^-depth of exactly 1.
  task automatic verify_tree(input int len_limit);
    int kraft;
    kraft = 0;
    for (int i = 0; i < num_sym; i++)
    begin
      if (freq_of_sym[i] == 0)
        compare_val($sformatf("sym_depth[%0d]", i), sym_depth[i], 0);
      else if (sym_depth[i] == 0 || sym_depth[i] > len_limit)
      begin
        $display("[ERROR] %0d ns: sym_depth[%0d] = %0d, outside 1 to %0d",
                 $time, i, sym_depth[i], len_limit);
        errors++;
      end
      else
        kraft += 1 << (15 - int'(sym_depth[i]));
    end
    compare_val("kraft_sum_x32768", kraft, 1 << 15);
  endtask

  //--------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------
  task automatic reset_state_test();
    int err_before;
    err_before = errors;
    compare_val("busy", busy, 0);
    compare_val("done", done, 0);
    compare_val("build_error", build_error, 0);
    compare_val("rebuild_pulse", rebuild_pulse, 0);
    compare_val("rebuild_failed", rebuild_failed, 0);
    for (int i = 0; i < num_sym; i++)
      compare_val($sformatf("sym_depth[%0d]", i), sym_depth[i], 0);
    report_test("reset state", err_before);
  endtask

  task automatic known_block_test();
    int   err_before;
    int   pulses;
    logic failed;
    int   blk_freq [5];
    int   exp_depth [5];
    err_before  = errors;
    blk_freq    = '{1, 1, 2, 4, 8};
    exp_depth   = '{4, 4, 3, 2, 1};
    freq_of_sym = '{default: 0};
    for (int i = 0; i < 5; i++)
      freq_of_sym[i] = blk_freq[i];
    start_build();
    wait_done(pulses, failed);
    for (int i = 0; i < 5; i++)
      compare_val($sformatf("sym_depth[%0d]", i), sym_depth[i], exp_depth[i]);
    verify_tree(15);
    compare_val("rebuild_pulse count", pulses, 0);
    compare_val("build_error", build_error, 0);
    compare_val("rebuild_failed", failed, 0);
    compare_val("zero_symbols", zero_symbols, 0);
    report_test("known depths", err_before);
  endtask

  task automatic random_block_test();
    int   err_before;
    int   pulses;
    logic failed;
    int   f;
    err_before  = errors;
    freq_of_sym = '{default: 0};
    for (int i = 0; i < 8; i++)
    begin
      f = random_bits(8);
      freq_of_sym[2*i+1] = (f == 0) ? 1 : f;  // Odd symbols carry the data.
    end
    start_build();
    wait_done(pulses, failed);
    verify_tree(15);
    compare_val("rebuild_pulse count", pulses, 0);
    compare_val("build_error", build_error, 0);
    compare_val("rebuild_failed", failed, 0);
    report_test("random block", err_before);
  endtask

  task automatic rebuild_fit_test();
    int   err_before;
    int   pulses;
    logic failed;
    int   blk_freq [7];
    err_before  = errors;
    blk_freq    = '{1, 1, 2, 4, 8, 16, 32};
    freq_of_sym = '{default: 0};
    for (int i = 0; i < 7; i++)
      freq_of_sym[i] = blk_freq[i];
    cfg_write(1'b0, 4);
    start_build();
    wait_done(pulses, failed);
    if (pulses < 1)
    begin
      $display("Block that needs 6 levels finished under max_len 4 without a rebuild");
      errors++;
    end
    verify_tree(4);
    compare_val("build_error", build_error, 0);
    compare_val("rebuild_failed", failed, 0);
    report_test("rebuild to fit", err_before);
  endtask

  task automatic rebuild_fail_test();
    int   err_before;
    int   pulses;
    logic failed;
    err_before = errors;
    cfg_write(1'b0, 2);
    cfg_write(1'b1, 0);
    start_build();  // Same seven symbols as the previous test.
    wait_done(pulses, failed);
    compare_val("build_error", build_error, 1);
    compare_val("rebuild_failed", failed, 1);
    compare_val("rebuild_pulse count", pulses, 0);
    cfg_write(1'b0, cfg_max_len_default);
    cfg_write(1'b1, cfg_rebuild_limit_default);
    report_test("rebuild limit reached", err_before);
  endtask

  task automatic stalled_zero_test();
    int   err_before;
    int   pulses;
    logic failed;
    err_before  = errors;
    freq_of_sym = '{default: 0};
    out_stall   = 1'b1;
    start_build();
    for (int k = 0; k < stall_cycles; k++)
    begin
      compare_val("done", done, 0);
      compare_val("busy", busy, 1);
      @(posedge clk);
      #1;
    end
    out_stall = 1'b0;
    wait_done(pulses, failed);
    compare_val("zero_symbols", zero_symbols, 1);
    compare_val("build_error", build_error, 0);
    compare_val("rebuild_pulse count", pulses, 0);
    compare_val("rebuild_failed", failed, 0);
    for (int i = 0; i < num_sym; i++)
      compare_val($sformatf("sym_depth[%0d]", i), sym_depth[i], 0);
    report_test("all-zero block under stall", err_before);
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial
  begin
    rst_n        = 1'b0;
    start        = 1'b0;
    out_stall    = 1'b0;
    cfg_wr       = 1'b0;
    cfg_addr     = 1'b0;
    cfg_wdata    = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 16'd13365;
    freq_of_sym  = '{default: 0};
    for (int i = 0; i < num_sym; i++)
    begin
      sym_freq[i] = '0;
      sym_id[i]   = sym_t'(i);
    end

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    reset_state_test();
    known_block_test();
    random_block_test();
    rebuild_fit_test();
    rebuild_fail_test();
    stalled_zero_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: list.f
huf_pkg.sv
htb_cfg_regs.sv
htb_input_store.sv
htb_merge_engine.sv
htb_depth_tracker.sv
htb_ctrl.sv
huf_tree_builder.sv
tb_huf_tree_builder.sv

// File: Makefile
# Verilator lint and simulation of the Huffman tree builder.

VERILATOR  ?= verilator
TOP        ?= tb_huf_tree_builder
RTL_TOP    ?= huf_tree_builder
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Testbench failed
PASS_MSG   ?= Testbench passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation finished without errors"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
